// ==== hw/ntm_ctrl_pkg.sv ====
// Control types: opcode and sequencer state enums, dimension type, command struct
package ntm_ctrl_pkg;

  ////////////////////
  // Dimensions
  ////////////////////

  // Loop bound or loop index
  typedef logic [7:0] dim_t;

  ////////////////////
  // Opcodes
  ////////////////////

  // Two-bit code, 2'b11 left free and treated as illegal
  typedef enum logic [1:0] {
    // Length only
    OP_VECTOR = 2'b00,
    // Rows by columns
    OP_MATRIX = 2'b01,
    // Rows by columns by length
    OP_TENSOR = 2'b10
  } op_e;

  ////////////////////
  // Sequencer states
  ////////////////////

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } seq_state_e;

  // Host command, sampled with the start pulse
  typedef struct packed {
    op_e  op;
    // Outer loop bound
    dim_t size_i;
    // Middle loop bound
    dim_t size_j;
    // Inner loop bound
    dim_t length;
  } cmd_t;

endpackage

// ==== hw/ntm_data_pkg.sv ====
// Data types: default element widths, operand pair struct, result struct
package ntm_data_pkg;

  ////////////////////
  // Element format
  ////////////////////

  // Signed element width
  localparam int DATA_SIZE_DEF = 16;

  // Fraction bits of the fixed-point format
  localparam int FRAC_BITS_DEF = 8;

  ////////////////////
  // Operands
  ////////////////////

  // One operand pair per input strobe
  typedef struct packed {
    logic signed [DATA_SIZE_DEF-1:0] a;
    logic signed [DATA_SIZE_DEF-1:0] b;
  } operand_t;

  ////////////////////
  // Results
  ////////////////////

  typedef struct packed {
    // Rounded, saturated product
    logic signed [DATA_SIZE_DEF-1:0] value;
    // Product was clamped
    logic                            sat;
    // End of inner loop
    logic                            last_scalar;
    // End of middle loop
    logic                            last_vector;
    // End of outer loop
    logic                            last_matrix;
  } result_t;

endpackage

// ==== hw/ntm_command_decode.sv ====
// Command decode: START capture, per-opcode dimension normalisation, zero-dimension check
`timescale 1ns/1ps

module ntm_command_decode (
  input  logic               CLK,
  input  logic               RST,

  // Host side
  input  logic               start,
  input  ntm_ctrl_pkg::cmd_t cmd_in,

  // Sequencer running
  input  logic               busy,

  // Normalised command out
  output logic               cmd_valid,
  output ntm_ctrl_pkg::cmd_t cmd_out,
  output logic               cmd_error
);

  // Normalised copy of the incoming command
  ntm_ctrl_pkg::cmd_t norm_cmd;
  // Opcode known and used dimensions nonzero
  logic               legal;
  // Start that will be judged this cycle
  logic               take;

  // Also ignore a start while the previous one is still on its way to the sequencer
  assign take = start && !busy && !cmd_valid;

  ////////////////////
  // Normalise
  ////////////////////

  always_comb begin
    norm_cmd = cmd_in;
    legal    = 1'b0;
    case (cmd_in.op)
      ntm_ctrl_pkg::OP_VECTOR: begin
        // Single row, single column
        norm_cmd.size_i = ntm_ctrl_pkg::dim_t'(1);
        norm_cmd.size_j = ntm_ctrl_pkg::dim_t'(1);
        legal = (cmd_in.length != '0);
      end
      ntm_ctrl_pkg::OP_MATRIX: begin
        // One element per matrix cell
        norm_cmd.length = ntm_ctrl_pkg::dim_t'(1);
        legal = (cmd_in.size_i != '0) && (cmd_in.size_j != '0);
      end
      ntm_ctrl_pkg::OP_TENSOR: begin
        // All three bounds as given
        legal = (cmd_in.size_i != '0) && (cmd_in.size_j != '0) &&
                (cmd_in.length != '0);
      end
      default: begin
        // Free opcode code
        legal = 1'b0;
      end
    endcase
  end

  ////////////////////
  // Pulses
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cmd_valid <= 1'b0;
      cmd_error <= 1'b0;
    end else begin
      // Exactly one of the two per judged start
      cmd_valid <= take && legal;
      cmd_error <= take && !legal;
    end
  end

  // Command payload, held until the next judged start
  always_ff @(posedge CLK) begin
    if (take) begin
      cmd_out <= norm_cmd;
    end
  end

endmodule

// ==== hw/ntm_tensor_sequencer.sv ====
// Tensor sequencer: run FSM, matrix/vector/scalar loop indices, operand forwarding with loop-end marks
`timescale 1ns/1ps

module ntm_tensor_sequencer #(
  parameter int DATA_SIZE = ntm_data_pkg::DATA_SIZE_DEF
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Command from decode
  input  logic                   cmd_valid,
  input  ntm_ctrl_pkg::cmd_t     cmd,

  // Element stream in
  input  logic                   data_in_enable,
  input  ntm_data_pkg::operand_t data_in,

  // Run status
  output logic                   busy,

  // Element stream out
  output logic                   pair_valid,
  output ntm_data_pkg::operand_t pair,
  output logic                   last_scalar,
  output logic                   last_vector,
  output logic                   last_matrix,
  output logic                   last_all
);

  ////////////////////
  // Signals
  ////////////////////

  // FSM
  ntm_ctrl_pkg::seq_state_e state_q;

  // Loop bounds from the command
  ntm_ctrl_pkg::dim_t bound_i_q;
  ntm_ctrl_pkg::dim_t bound_j_q;
  ntm_ctrl_pkg::dim_t bound_l_q;

  // Loop indices, matrix outermost
  ntm_ctrl_pkg::dim_t idx_matrix_q;
  ntm_ctrl_pkg::dim_t idx_vector_q;
  ntm_ctrl_pkg::dim_t idx_scalar_q;

  // Element taken this cycle
  logic accept;

  // Loop level ends for the element taken now
  logic end_scalar;
  logic end_vector;
  logic end_matrix;

  // Operand registers
  logic signed [DATA_SIZE-1:0] a_q;
  logic signed [DATA_SIZE-1:0] b_q;

  ////////////////////
  // Loop ends
  ////////////////////

  assign accept = (state_q == ntm_ctrl_pkg::ST_RUN) && data_in_enable;

  // Each level ends only when every inner level ends too
  assign end_scalar = (idx_scalar_q == bound_l_q - 8'd1);
  assign end_vector = end_scalar && (idx_vector_q == bound_j_q - 8'd1);
  assign end_matrix = end_vector && (idx_matrix_q == bound_i_q - 8'd1);

  assign busy = (state_q == ntm_ctrl_pkg::ST_RUN);

  ////////////////////
  // FSM and indices
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= ntm_ctrl_pkg::ST_IDLE;
      bound_i_q    <= '0;
      bound_j_q    <= '0;
      bound_l_q    <= '0;
      idx_matrix_q <= '0;
      idx_vector_q <= '0;
      idx_scalar_q <= '0;
    end else begin
      case (state_q)
        ntm_ctrl_pkg::ST_IDLE: begin
          if (cmd_valid) begin
            // Bounds already normalised by decode
            bound_i_q    <= cmd.size_i;
            bound_j_q    <= cmd.size_j;
            bound_l_q    <= cmd.length;
            idx_matrix_q <= '0;
            idx_vector_q <= '0;
            idx_scalar_q <= '0;
            state_q      <= ntm_ctrl_pkg::ST_RUN;
          end
        end
        ntm_ctrl_pkg::ST_RUN: begin
          if (accept) begin
            if (end_scalar) begin
              // Scalar wraps into vector
              idx_scalar_q <= '0;
              if (end_vector) begin
                // Vector wraps into matrix
                idx_vector_q <= '0;
                if (end_matrix) begin
                  // Final element, run over
                  idx_matrix_q <= '0;
                  state_q      <= ntm_ctrl_pkg::ST_IDLE;
                end else begin
                  idx_matrix_q <= idx_matrix_q + 8'd1;
                end
              end else begin
                idx_vector_q <= idx_vector_q + 8'd1;
              end
            end else begin
              idx_scalar_q <= idx_scalar_q + 8'd1;
            end
          end
        end
        default: begin
          state_q <= ntm_ctrl_pkg::ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Output stage
  ////////////////////

  // Strobe and marks, one cycle behind the input strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pair_valid  <= 1'b0;
      last_scalar <= 1'b0;
      last_vector <= 1'b0;
      last_matrix <= 1'b0;
      last_all    <= 1'b0;
    end else begin
      pair_valid  <= accept;
      last_scalar <= accept && end_scalar;
      last_vector <= accept && end_vector;
      last_matrix <= accept && end_matrix;
      // Outer loop end is the end of the whole run
      last_all    <= accept && end_matrix;
    end
  end

  // Operands follow the strobe
  always_ff @(posedge CLK) begin
    if (accept) begin
      a_q <= data_in.a;
      b_q <= data_in.b;
    end
  end

  assign pair = '{a: a_q, b: b_q};

endmodule

// ==== hw/ntm_product_round.sv ====
// Result stage: signed fixed-point product, round half up, saturation, registered strobes
`timescale 1ns/1ps

module ntm_product_round #(
  parameter int DATA_SIZE = ntm_data_pkg::DATA_SIZE_DEF,
  parameter int FRAC_BITS = ntm_data_pkg::FRAC_BITS_DEF
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Element stream from the sequencer
  input  logic                   pair_valid,
  input  ntm_data_pkg::operand_t pair,
  input  logic                   last_scalar,
  input  logic                   last_vector,
  input  logic                   last_matrix,
  input  logic                   last_all,

  // Results
  output logic                   data_out_enable,
  output ntm_data_pkg::result_t  data_out,
  output logic                   ready
);

  localparam int PROD_W = 2 * DATA_SIZE;

  // Element range limits, widened to the product width
  localparam logic signed [PROD_W-1:0] SAT_MAX =
    {{(DATA_SIZE + 1){1'b0}}, {(DATA_SIZE - 1){1'b1}}};
  localparam logic signed [PROD_W-1:0] SAT_MIN =
    {{(DATA_SIZE + 1){1'b1}}, {(DATA_SIZE - 1){1'b0}}};

  // Half an output LSB
  localparam logic signed [PROD_W-1:0] HALF_LSB = PROD_W'(1) << (FRAC_BITS - 1);

  logic signed [PROD_W-1:0]    product;
  logic signed [PROD_W-1:0]    rounded;
  logic signed [PROD_W-1:0]    scaled;
  logic signed [DATA_SIZE-1:0] sat_value;
  logic                        sat_flag;

  ////////////////////
  // Arithmetic
  ////////////////////

  // Full-width product cannot overflow
  assign product = $signed(pair.a) * $signed(pair.b);
  assign rounded = product + HALF_LSB;
  // Arithmetic shift keeps the sign, so ties go toward plus infinity
  assign scaled  = rounded >>> FRAC_BITS;

  always_comb begin
    if (scaled > SAT_MAX) begin
      sat_value = SAT_MAX[DATA_SIZE-1:0];
      sat_flag  = 1'b1;
    end else if (scaled < SAT_MIN) begin
      sat_value = SAT_MIN[DATA_SIZE-1:0];
      sat_flag  = 1'b1;
    end else begin
      sat_value = scaled[DATA_SIZE-1:0];
      sat_flag  = 1'b0;
    end
  end

  ////////////////////
  // Output registers
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      data_out_enable <= pair_valid;
      // Ready rides on the final element only
      ready           <= pair_valid && last_all;
    end
  end

  // Result with its loop-end marks
  always_ff @(posedge CLK) begin
    if (pair_valid) begin
      data_out <= '{value:       sat_value,
                    sat:         sat_flag,
                    last_scalar: last_scalar,
                    last_vector: last_vector,
                    last_matrix: last_matrix};
    end
  end

endmodule

// ==== hw/ntm_tensor_mul.sv ====
// Top level: command decode, tensor sequencer and result stage
`timescale 1ns/1ps

module ntm_tensor_mul #(
  parameter int DATA_SIZE = ntm_data_pkg::DATA_SIZE_DEF,
  parameter int FRAC_BITS = ntm_data_pkg::FRAC_BITS_DEF
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Command
  input  logic                   START,
  input  ntm_ctrl_pkg::cmd_t     CMD,

  // Element stream in
  input  logic                   DATA_IN_ENABLE,
  input  ntm_data_pkg::operand_t DATA_IN,

  // Status
  output logic                   BUSY,
  output logic                   CMD_ERROR,

  // Element stream out
  output logic                   DATA_OUT_ENABLE,
  output ntm_data_pkg::result_t  DATA_OUT,
  output logic                   READY
);

  ////////////////////
  // Internal wires
  ////////////////////

  // Decode to sequencer
  logic                   cmd_valid;
  ntm_ctrl_pkg::cmd_t     cmd_norm;

  // Sequencer to result stage
  logic                   pair_valid;
  ntm_data_pkg::operand_t pair;
  logic                   last_scalar;
  logic                   last_vector;
  logic                   last_matrix;
  logic                   last_all;

  // Command check
  ntm_command_decode i_decode (
    .CLK       (CLK),
    .RST       (RST),
    .start     (START),
    .cmd_in    (CMD),
    .busy      (BUSY),
    .cmd_valid (cmd_valid),
    .cmd_out   (cmd_norm),
    .cmd_error (CMD_ERROR)
  );

  // Nested loop control
  ntm_tensor_sequencer #(
    .DATA_SIZE (DATA_SIZE)
  ) i_sequencer (
    .CLK            (CLK),
    .RST            (RST),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd_norm),
    .data_in_enable (DATA_IN_ENABLE),
    .data_in        (DATA_IN),
    .busy           (BUSY),
    .pair_valid     (pair_valid),
    .pair           (pair),
    .last_scalar    (last_scalar),
    .last_vector    (last_vector),
    .last_matrix    (last_matrix),
    .last_all       (last_all)
  );

  // Multiply, round, saturate
  ntm_product_round #(
    .DATA_SIZE (DATA_SIZE),
    .FRAC_BITS (FRAC_BITS)
  ) i_product (
    .CLK             (CLK),
    .RST             (RST),
    .pair_valid      (pair_valid),
    .pair            (pair),
    .last_scalar     (last_scalar),
    .last_vector     (last_vector),
    .last_matrix     (last_matrix),
    .last_all        (last_all),
    .data_out_enable (DATA_OUT_ENABLE),
    .data_out        (DATA_OUT),
    .ready           (READY)
  );

endmodule

// ==== tests/ntm_tensor_mul_tb.sv ====
// Tensor multiplier testbench with clock, reset, file stimulus, compare tasks and timeout
`timescale 1ns/1ps

module ntm_tensor_mul_tb;

  localparam int    DW         = ntm_data_pkg::DATA_SIZE_DEF;
  localparam string INPUT_FILE = "tests/ntm_tensor_mul_input.txt";

  ////////////////////
  // DUT signals
  ////////////////////

  logic                   CLK;
  logic                   RST;
  logic                   START;
  ntm_ctrl_pkg::cmd_t     CMD;
  logic                   DATA_IN_ENABLE;
  ntm_data_pkg::operand_t DATA_IN;
  logic                   BUSY;
  logic                   CMD_ERROR;
  logic                   DATA_OUT_ENABLE;
  ntm_data_pkg::result_t  DATA_OUT;
  logic                   READY;

  // Expected results in output order
  ntm_data_pkg::result_t exp_q[$];

  int     n_mismatch;
  int     n_other;
  int     n_checked;
  int     cycles;
  int     cycle_limit;
  integer seed;

  ntm_tensor_mul #(
    .DATA_SIZE (ntm_data_pkg::DATA_SIZE_DEF),
    .FRAC_BITS (ntm_data_pkg::FRAC_BITS_DEF)
  ) i_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .CMD             (CMD),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .DATA_IN         (DATA_IN),
    .BUSY            (BUSY),
    .CMD_ERROR       (CMD_ERROR),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .READY           (READY)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_result(input ntm_data_pkg::result_t got,
                              input ntm_data_pkg::result_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch DATA_OUT output %0d: got %h expected %h", n_checked, got, exp);
      $display("  value %h/%h sat %h/%h marks %h%h%h/%h%h%h",
               got.value, exp.value, got.sat, exp.sat,
               got.last_scalar, got.last_vector, got.last_matrix,
               exp.last_scalar, exp.last_vector, exp.last_matrix);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  // Output check on every falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_ENABLE) begin
        if (exp_q.size() == 0) begin
          n_other++;
          $display("Output appeared with no element pending, DATA_OUT %h", DATA_OUT);
        end else begin
          check_result(DATA_OUT, exp_q[0]);
          // Ready only with the final element of a run
          check_flag(READY, exp_q[0].last_matrix, "READY");
          void'(exp_q.pop_front());
          n_checked++;
        end
      end else begin
        check_flag(READY, 1'b0, "READY");
      end
    end
  end

  // Run limit from the element count of the input file
  always @(posedge CLK) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("Summary: %0d mismatches, %0d other errors, %0d outputs checked",
               n_mismatch, n_other, n_checked);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    while (BUSY !== level && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (BUSY !== level) begin
      n_other++;
      $display("BUSY did not reach %0b within %0d cycles", level, limit);
    end
  endtask

  // Waits for pending outputs and reports any that never came
  task automatic drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (exp_q.size() > 0) begin
      n_other += exp_q.size();
      $display("%0d expected outputs never appeared", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic send_command(input int op, input int size_i, input int size_j,
                              input int length, input int exp_err, input int exp_run);
    ntm_ctrl_pkg::cmd_t cmd;
    cmd.op     = ntm_ctrl_pkg::op_e'(op[1:0]);
    cmd.size_i = size_i[7:0];
    cmd.size_j = size_j[7:0];
    cmd.length = length[7:0];
    @(posedge CLK);
    START          <= 1'b1;
    CMD            <= cmd;
    DATA_IN_ENABLE <= 1'b0;
    @(posedge CLK);
    START <= 1'b0;
    // Decode answers one cycle after START
    @(negedge CLK);
    check_flag(CMD_ERROR, exp_err[0], "CMD_ERROR");
    if (exp_run != 0) begin
      wait_busy(1'b1, 4);
    end else if (exp_err != 0) begin
      // Single pulse and no run after it
      repeat (3) begin
        @(negedge CLK);
        check_flag(CMD_ERROR, 1'b0, "CMD_ERROR");
        check_flag(BUSY, 1'b0, "BUSY");
      end
    end else begin
      // Start during a run leaves the run going
      check_flag(BUSY, 1'b1, "BUSY");
    end
  endtask

  task automatic send_element(input int a, input int b, input int gap, input int value,
                              input int sat, input int ls, input int lv, input int lm);
    ntm_data_pkg::result_t  exp;
    ntm_data_pkg::operand_t pair;
    int                     idle;
    idle = gap;
    if (gap < 0) begin
      idle = int'({$random(seed)} % 32'd4);
    end
    pair.a          = a[DW-1:0];
    pair.b          = b[DW-1:0];
    exp.value       = value[DW-1:0];
    exp.sat         = sat[0];
    exp.last_scalar = ls[0];
    exp.last_vector = lv[0];
    exp.last_matrix = lm[0];
    repeat (idle) begin
      @(posedge CLK);
      DATA_IN_ENABLE <= 1'b0;
    end
    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b1;
    DATA_IN        <= pair;
    exp_q.push_back(exp);
  endtask

  // After the final element BUSY drops in the next cycle
  task automatic end_run;
    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b0;
    @(negedge CLK);
    check_flag(BUSY, 1'b0, "BUSY");
    drain(6);
  endtask

  task automatic stray_strobe(input int a, input int b);
    ntm_data_pkg::operand_t pair;
    pair.a = a[DW-1:0];
    pair.b = b[DW-1:0];
    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b1;
    DATA_IN        <= pair;
    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b0;
    // Monitor flags any output that follows
    repeat (4) begin
      @(negedge CLK);
      check_flag(BUSY, 1'b0, "BUSY");
    end
  endtask

  ////////////////////
  // Main flow
  ////////////////////

  initial begin : main_flow
    string line;
    int    fd;
    int    n_elem;
    int    n_fields;
    byte   kind;
    int    op;
    int    si;
    int    sj;
    int    len;
    int    err;
    int    run;
    int    a;
    int    b;
    int    gap;
    int    value;
    int    sat;
    int    ls;
    int    lv;
    int    lm;

    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    CMD            = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN        = '0;
    n_mismatch     = 0;
    n_other        = 0;
    n_checked      = 0;
    cycles         = 0;
    cycle_limit    = 0;
    seed           = 32'h4977;
    n_elem         = 0;

    // First pass counts strobes for the run limit
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      n_other++;
      $display("Cannot open the input file %s", INPUT_FILE);
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          kind = line.getc(0);
          if (kind == "E" || kind == "S") begin
            n_elem++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 20 * n_elem + 200;

    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    fd = $fopen(INPUT_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          kind = line.getc(0);
          case (kind)
            "C": begin
              n_fields = $sscanf(line, "C %d %d %d %d %d %d", op, si, sj, len, err, run);
              if (n_fields != 6) begin
                n_other++;
                $display("Malformed command line in the input file");
              end else begin
                send_command(op, si, sj, len, err, run);
              end
            end
            "E": begin
              n_fields = $sscanf(line, "E %h %h %d %h %d %d %d %d",
                                 a, b, gap, value, sat, ls, lv, lm);
              if (n_fields != 8) begin
                n_other++;
                $display("Malformed element line in the input file");
              end else begin
                send_element(a, b, gap, value, sat, ls, lv, lm);
                if (lm != 0) begin
                  end_run();
                end
              end
            end
            "S": begin
              n_fields = $sscanf(line, "S %h %h", a, b);
              if (n_fields != 2) begin
                n_other++;
                $display("Malformed stray strobe line in the input file");
              end else begin
                stray_strobe(a, b);
              end
            end
            default: begin
              // comment or blank line
            end
          endcase
        end
      end
      $fclose(fd);
    end

    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b0;
    drain(8);

    $display("Summary: %0d mismatches, %0d other errors, %0d outputs checked",
             n_mismatch, n_other, n_checked);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tests/ntm_tensor_mul_input.txt ====
# C op size_i size_j length exp_error exp_run (op 0 vector, 1 matrix, 2 tensor, 3 unused)
# E a b gap value sat last_scalar last_vector last_matrix (hex a b value, gap -1 random)
# S a b (strobe while idle, no output expected)
S 0100 0100
C 2 2 2 3 0 1
E 0100 0100 0 0100 0 0 0 0
E 0180 0200 0 0300 0 0 0 0
E 0080 0081 0 0041 0 1 0 0
E fff0 0008 0 0000 0 0 0 0
E fff0 0009 0 ffff 0 0 0 0
E ff00 0300 0 fd00 0 1 1 0
E 7fff 7fff 0 7fff 1 0 0 0
E 8000 7fff 0 8000 1 0 0 0
E 8000 8000 0 7fff 1 1 0 0
E 0100 7fff 0 7fff 0 0 0 0
E ff00 8000 0 7fff 1 0 0 0
E 0100 8000 0 8000 0 1 1 1
C 2 2 0 3 1 0
C 0 3 3 0 1 0
C 3 1 1 1 1 0
C 1 0 4 9 1 0
C 0 0 0 4 0 1
E 0200 0040 -1 0080 0 0 0 0
E fe00 0040 -1 ff80 0 0 0 0
C 2 1 1 1 0 0
E 0003 0003 -1 0000 0 0 0 0
E fffd 0003 -1 0000 0 1 1 1
S 0200 0200
C 1 2 3 0 0 1
E 0010 0010 1 0001 0 1 0 0
E 0018 0010 -1 0002 0 1 0 0
E ffe8 0010 0 ffff 0 1 1 0
E 0a00 0a00 -1 6400 0 1 0 0
E f600 0d00 2 8000 1 1 0 0
E 7fff 0080 0 4000 0 1 1 1

// ==== ntm_tensor_mul.f ====
hw/ntm_ctrl_pkg.sv
hw/ntm_data_pkg.sv
hw/ntm_command_decode.sv
hw/ntm_tensor_sequencer.sv
hw/ntm_product_round.sv
hw/ntm_tensor_mul.sv
tests/ntm_tensor_mul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tensor multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module ntm_tensor_mul_tb \
  -f ntm_tensor_mul.f -o ntm_tensor_mul_sim
./obj_dir/ntm_tensor_mul_sim | tee sim.log
if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
